// ==== design/exu_width_pkg.sv ====
package exu_width_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Datapath widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int xlen       = 32;
	localparam int dword_len  = 2 * xlen;
	localparam int funct3_len = 3;
	localparam int count_len  = 6;                      // Holds xlen-1 with room to spare

	typedef logic [xlen-1:0]       data_t;              // Operands, immediates, pc, results
	typedef logic [dword_len-1:0]  dword_t;             // Full product
	typedef logic [funct3_len-1:0] funct3_t;
	typedef logic [count_len-1:0]  count_t;             // Mul/div iteration counter

	// Size of one instruction, added to pc for the link address
	localparam data_t inst_bytes = data_t'(4);

	// Last iteration index of the sequential units
	localparam count_t last_step = count_t'(xlen - 1);

	// Most negative signed value
	localparam data_t min_signed = {1'b1, {(xlen-1){1'b0}}};

endpackage

// ==== design/exu_op_pkg.sv ====
package exu_op_pkg;

	import exu_width_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU operations
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [3:0] {
		alu_add    = 4'h0,
		alu_sub    = 4'h1,
		alu_sll    = 4'h2,
		alu_slt    = 4'h3,
		alu_sltu   = 4'h4,
		alu_xor    = 4'h5,
		alu_srl    = 4'h6,
		alu_sra    = 4'h7,
		alu_or     = 4'h8,
		alu_and    = 4'h9,
		alu_pass_b = 4'ha      // lui
	} alu_op_t;

	// Operand source pairs (a, b)
	typedef enum logic [1:0] {
		rs1_rs2 = 2'd0,
		rs1_imm = 2'd1,
		pc_4    = 2'd2,
		pc_imm  = 2'd3
	} src_sel_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// funct3 codes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam funct3_t f3_beq    = 3'b000;
	localparam funct3_t f3_bne    = 3'b001;
	localparam funct3_t f3_blt    = 3'b100;
	localparam funct3_t f3_bge    = 3'b101;
	localparam funct3_t f3_bltu   = 3'b110;
	localparam funct3_t f3_bgeu   = 3'b111;

	localparam funct3_t f3_mul    = 3'b000;
	localparam funct3_t f3_mulh   = 3'b001;
	localparam funct3_t f3_mulhsu = 3'b010;
	localparam funct3_t f3_mulhu  = 3'b011;

	localparam funct3_t f3_div    = 3'b100;
	localparam funct3_t f3_divu   = 3'b101;
	localparam funct3_t f3_rem    = 3'b110;
	localparam funct3_t f3_remu   = 3'b111;

endpackage

// ==== design/exu_alu.sv ====
module exu_alu
	import exu_width_pkg::*;
	import exu_op_pkg::*;
(
	input  data_t   a,
	input  data_t   b,
	input  alu_op_t alu_op,
	output data_t   result
);

	logic [4:0] shamt;
	logic       less_signed;
	logic       less_unsigned;

	assign shamt         = b[4:0];                    // RV32I uses five shift bits
	assign less_signed   = $signed(a) < $signed(b);
	assign less_unsigned = a < b;

	always_comb begin
		case (alu_op)
			alu_add: begin
				result = a + b;
			end
			alu_sub: begin
				result = a - b;
			end
			alu_sll: begin
				result = a << shamt;
			end
			alu_slt: begin
				result = data_t'(less_signed);
			end
			alu_sltu: begin
				result = data_t'(less_unsigned);
			end
			alu_xor: begin
				result = a ^ b;
			end
			alu_srl: begin
				result = a >> shamt;
			end
			alu_sra: begin
				result = data_t'($signed(a) >>> shamt);
			end
			alu_or: begin
				result = a | b;
			end
			alu_and: begin
				result = a & b;
			end
			alu_pass_b: begin
				result = b;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// ==== design/exu_multiplier.sv ====
module exu_multiplier
	import exu_width_pkg::*;
	import exu_op_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    start,
	input  data_t   multiplicand,
	input  data_t   multiplier,
	input  funct3_t funct3,
	output logic    busy,
	output logic    done,
	output data_t   result
);

	typedef enum logic [1:0] {
		idle,
		run,
		finish
	} state_t;

	state_t        state;
	count_t        count;
	dword_t        product;        // {partial sum, remaining multiplier bits}
	data_t         mcand;
	logic          negate;
	logic          high_word;

	logic          a_signed;
	logic          b_signed;
	logic          a_neg;
	logic          b_neg;
	data_t         a_mag;
	data_t         b_mag;
	logic [xlen:0] partial;
	dword_t        signed_product;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Operand magnitudes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		a_signed = (funct3 == f3_mul) || (funct3 == f3_mulh) || (funct3 == f3_mulhsu);
		b_signed = (funct3 == f3_mul) || (funct3 == f3_mulh);
		a_neg    = a_signed && multiplicand[xlen-1];
		b_neg    = b_signed && multiplier[xlen-1];
		a_mag    = a_neg ? -multiplicand : multiplicand;
		b_mag    = b_neg ? -multiplier : multiplier;
	end

	// Add the multiplicand when the current multiplier bit is set
	assign partial = {1'b0, product[dword_len-1:xlen]} + (product[0] ? {1'b0, mcand} : '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			count <= '0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						state <= run;
						count <= '0;
					end
				end
				run: begin
					count <= count + 1'b1;
					if (count == last_step)
						state <= finish;
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == idle && start) begin
			product   <= {{xlen{1'b0}}, b_mag};
			mcand     <= a_mag;
			negate    <= a_neg ^ b_neg;
			high_word <= (funct3 != f3_mul);
		end else if (state == run) begin
			product <= {partial, product[xlen-1:1]};                 // Shift right one step
		end
	end

	assign signed_product = negate ? -product : product;
	assign result         = high_word ? signed_product[dword_len-1:xlen] : signed_product[xlen-1:0];
	assign busy           = (state == run);
	assign done           = (state == finish);

	// The top level must hold off a new launch until the unit is free
	start_while_busy: assert property (@(posedge clock) disable iff (reset) start |-> !busy);

endmodule

// ==== design/exu_divider.sv ====
module exu_divider
	import exu_width_pkg::*;
	import exu_op_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    start,
	input  data_t   dividend,
	input  data_t   divisor,
	input  funct3_t funct3,
	output logic    busy,
	output logic    done,
	output data_t   result
);

	typedef enum logic [1:0] {
		idle,
		run,
		finish
	} state_t;

	state_t          state;
	count_t          count;
	data_t           quotient;      // Also shifts out the dividend bits
	data_t           remainder;
	data_t           dsor;
	logic            quot_neg;
	logic            rem_neg;
	logic            rem_sel;

	logic            is_signed;
	logic            want_rem;
	logic            dividend_neg;
	logic            divisor_neg;
	data_t           dividend_mag;
	data_t           divisor_mag;
	logic            div_zero;
	logic            overflow;
	logic [xlen+1:0] trial;

	always_comb begin
		is_signed    = (funct3 == f3_div) || (funct3 == f3_rem);
		want_rem     = (funct3 == f3_rem) || (funct3 == f3_remu);
		dividend_neg = is_signed && dividend[xlen-1];
		divisor_neg  = is_signed && divisor[xlen-1];
		dividend_mag = dividend_neg ? -dividend : dividend;
		divisor_mag  = divisor_neg ? -divisor : divisor;
		div_zero     = (divisor == '0);
		overflow     = is_signed && (dividend == min_signed) && (divisor == '1);
	end

	// Shift in the next dividend bit and try to subtract
	assign trial = {1'b0, remainder, quotient[xlen-1]} - {2'b00, dsor};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			count <= '0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						state <= (div_zero || overflow) ? finish : run;   // Special cases skip the loop
						count <= '0;
					end
				end
				run: begin
					count <= count + 1'b1;
					if (count == last_step)
						state <= finish;
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Datapath
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock) begin
		if (state == idle && start) begin
			rem_sel <= want_rem;
			dsor    <= divisor_mag;
			if (div_zero) begin
				quotient  <= '1;
				remainder <= dividend;
				quot_neg  <= 1'b0;
				rem_neg   <= 1'b0;
			end else if (overflow) begin
				quotient  <= dividend;
				remainder <= '0;
				quot_neg  <= 1'b0;
				rem_neg   <= 1'b0;
			end else begin
				quotient  <= dividend_mag;
				remainder <= '0;
				quot_neg  <= dividend_neg ^ divisor_neg;
				rem_neg   <= dividend_neg;                 // Remainder takes the dividend sign
			end
		end else if (state == run) begin
			if (!trial[xlen+1]) begin
				remainder <= trial[xlen-1:0];
				quotient  <= {quotient[xlen-2:0], 1'b1};
			end else begin
				remainder <= {remainder[xlen-2:0], quotient[xlen-1]};
				quotient  <= {quotient[xlen-2:0], 1'b0};
			end
		end
	end

	assign result = rem_sel ? (rem_neg ? -remainder : remainder)
	                        : (quot_neg ? -quotient : quotient);
	assign busy   = (state == run);
	assign done   = (state == finish);

	done_single_pulse: assert property (@(posedge clock) disable iff (reset) done |=> !done);

endmodule

// ==== design/exu.sv ====
module exu
	import exu_width_pkg::*;
	import exu_op_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  data_t    pc,
	input  data_t    src1,
	input  data_t    src2,
	input  data_t    imm,
	input  alu_op_t  alu_op,
	input  src_sel_t src_sel,
	input  funct3_t  funct3,
	input  logic     branch,
	input  logic     alu_mul,
	input  logic     alu_div,
	input  logic     id_to_ex,
	input  logic     ex_to_wb,
	output data_t    exu_result,
	output logic     exu_finished,
	output logic     exu_stall,
	output logic     zero_flag
);

	data_t alu_a;
	data_t alu_b;
	data_t alu_out;
	logic  branch_taken;
	data_t branch_result;
	logic  alu_pending;

	logic  mul_start;
	logic  mul_busy;
	logic  mul_done;
	data_t mul_result;
	logic  div_start;
	logic  div_busy;
	logic  div_done;
	data_t div_result;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Operand select and ALU
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		case (src_sel)
			rs1_rs2: begin
				alu_a = src1;
				alu_b = src2;
			end
			rs1_imm: begin
				alu_a = src1;
				alu_b = imm;
			end
			pc_4: begin
				alu_a = pc;
				alu_b = inst_bytes;              // Link address
			end
			default: begin
				alu_a = pc;
				alu_b = imm;
			end
		endcase
	end

	exu_alu alu_inst (
		.a      (alu_a),
		.b      (alu_b),
		.alu_op (alu_op),
		.result (alu_out)
	);

	// beq/bne look at the sub result, the others at slt/sltu bit 0
	always_comb begin
		case (funct3)
			f3_beq:           branch_taken = (alu_out == '0);
			f3_bne:           branch_taken = (alu_out != '0);
			f3_blt, f3_bltu:  branch_taken = alu_out[0];
			f3_bge, f3_bgeu:  branch_taken = !alu_out[0];
			default:          branch_taken = 1'b0;
		endcase
	end

	assign branch_result = data_t'(branch_taken);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Launch of the long units
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign mul_start = id_to_ex && alu_mul && !exu_finished;    // Held off while result waits
	assign div_start = id_to_ex && alu_div && !exu_finished;

	exu_multiplier multiplier_inst (
		.clock        (clock),
		.reset        (reset),
		.start        (mul_start),
		.multiplicand (alu_a),
		.multiplier   (alu_b),
		.funct3       (funct3),
		.busy         (mul_busy),
		.done         (mul_done),
		.result       (mul_result)
	);

	exu_divider divider_inst (
		.clock    (clock),
		.reset    (reset),
		.start    (div_start),
		.dividend (alu_a),
		.divisor  (alu_b),
		.funct3   (funct3),
		.busy     (div_busy),
		.done     (div_done),
		.result   (div_result)
	);

	always_ff @(posedge clock) begin
		if (reset)
			alu_pending <= 1'b0;
		else
			alu_pending <= id_to_ex && !alu_mul && !alu_div && !exu_finished;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Result buffer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock) begin
		if (reset) begin
			exu_result   <= '0;
			exu_finished <= 1'b0;
		end else if (mul_done) begin
			exu_result   <= mul_result;
			exu_finished <= 1'b1;
		end else if (div_done) begin
			exu_result   <= div_result;
			exu_finished <= 1'b1;
		end else if (alu_pending) begin
			exu_result   <= branch ? branch_result : alu_out;
			exu_finished <= 1'b1;
		end else if (ex_to_wb) begin
			exu_finished <= 1'b0;                // Writeback took it
		end
	end

	// Stall covers the result cycle of the unit too
	assign exu_stall = mul_busy || mul_done || div_busy || div_done;
	assign zero_flag = (exu_result == '0);

	stall_finished_excl: assert property (@(posedge clock) disable iff (reset)
		!(exu_stall && exu_finished));

endmodule

// ==== verif/exu_tb.sv ====
module exu_tb
	import exu_width_pkg::*;
	import exu_op_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// {branch, alu_mul, alu_div}
	localparam logic [2:0] k_br  = 3'b100;
	localparam logic [2:0] k_mul = 3'b010;
	localparam logic [2:0] k_div = 3'b001;

	typedef struct packed {
		alu_op_t  alu_op;
		src_sel_t src_sel;
		funct3_t  funct3;
		logic     branch;
		logic     alu_mul;
		logic     alu_div;
		data_t    pc;
		data_t    src1;
		data_t    src2;
		data_t    imm;
		data_t    expected;
	} entry_t;

	logic     clock;
	logic     reset;
	data_t    pc;
	data_t    src1;
	data_t    src2;
	data_t    imm;
	alu_op_t  alu_op;
	src_sel_t src_sel;
	funct3_t  funct3;
	logic     branch;
	logic     alu_mul;
	logic     alu_div;
	logic     id_to_ex;
	logic     ex_to_wb;
	data_t    exu_result;
	logic     exu_finished;
	logic     exu_stall;
	logic     zero_flag;

	entry_t   entries[$];
	bit       table_ready;
	int       check_count;
	int       error_count;

	exu exu_inst (
		.clock        (clock),
		.reset        (reset),
		.pc           (pc),
		.src1         (src1),
		.src2         (src2),
		.imm          (imm),
		.alu_op       (alu_op),
		.src_sel      (src_sel),
		.funct3       (funct3),
		.branch       (branch),
		.alu_mul      (alu_mul),
		.alu_div      (alu_div),
		.id_to_ex     (id_to_ex),
		.ex_to_wb     (ex_to_wb),
		.exu_result   (exu_result),
		.exu_finished (exu_finished),
		.exu_stall    (exu_stall),
		.zero_flag    (zero_flag)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic check_value(input string name, input data_t got, input data_t expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic add_alu(input alu_op_t op, input src_sel_t sel, input data_t pc_val,
			input data_t s1, input data_t s2, input data_t imm_val, input data_t exp);
		entry_t e;
		e          = '0;
		e.alu_op   = op;
		e.src_sel  = sel;
		e.pc       = pc_val;
		e.src1     = s1;
		e.src2     = s2;
		e.imm      = imm_val;
		e.expected = exp;
		entries.push_back(e);
	endtask

	// Branch, multiply and divide entries, all register operands
	task automatic add_f3(input logic [2:0] kind, input funct3_t f3, input data_t s1,
			input data_t s2, input data_t exp);
		entry_t e;
		e         = '0;
		e.src_sel = rs1_rs2;
		e.funct3  = f3;
		{e.branch, e.alu_mul, e.alu_div} = kind;
		e.src1     = s1;
		e.src2     = s2;
		e.expected = exp;
		if (kind == k_br)
			e.alu_op = !f3[2] ? alu_sub : (f3[1] ? alu_sltu : alu_slt);   // Decode of the compare
		else
			e.alu_op = alu_add;
		entries.push_back(e);
	endtask

	task automatic fill_table();
		add_alu(alu_add,    rs1_rs2, 32'h0, 32'h8000_0010, 32'h4, 32'h0, 32'h8000_0014);
		add_alu(alu_sub,    rs1_rs2, 32'h0, 32'h8000_0010, 32'h4, 32'h0, 32'h8000_000c);
		add_alu(alu_sll,    rs1_rs2, 32'h0, 32'h8000_0010, 32'h4, 32'h0, 32'h0000_0100);
		add_alu(alu_slt,    rs1_rs2, 32'h0, 32'h8000_0010, 32'h4, 32'h0, 32'h1);
		add_alu(alu_sltu,   rs1_rs2, 32'h0, 32'h8000_0010, 32'h4, 32'h0, 32'h0);
		add_alu(alu_xor,    rs1_rs2, 32'h0, 32'h8000_0010, 32'h4, 32'h0, 32'h8000_0014);
		add_alu(alu_srl,    rs1_rs2, 32'h0, 32'h8000_0010, 32'h4, 32'h0, 32'h0800_0001);
		add_alu(alu_sra,    rs1_rs2, 32'h0, 32'h8000_0010, 32'h4, 32'h0, 32'hf800_0001);
		add_alu(alu_or,     rs1_rs2, 32'h0, 32'h8000_0010, 32'h4, 32'h0, 32'h8000_0014);
		add_alu(alu_and,    rs1_rs2, 32'h0, 32'h8000_0010, 32'h4, 32'h0, 32'h0);
		add_alu(alu_pass_b, rs1_rs2, 32'h0, 32'h8000_0010, 32'h4, 32'h0, 32'h4);
		add_alu(alu_add,    rs1_imm, 32'h0, 32'hff, 32'h7, 32'hffff_fff0, 32'hef);
		add_alu(alu_and,    rs1_imm, 32'h0, 32'hff, 32'h7, 32'hffff_fff0, 32'hf0);
		add_alu(alu_sltu,   rs1_imm, 32'h0, 32'hff, 32'h7, 32'hffff_fff0, 32'h1);
		add_alu(alu_pass_b, rs1_imm, 32'h0, 32'hff, 32'h7, 32'h1234_5000, 32'h1234_5000);
		add_alu(alu_add,    pc_4,    32'h1000, 32'h55, 32'h7, 32'h40, 32'h1004);
		add_alu(alu_add,    pc_imm,  32'h1000, 32'h55, 32'h7, 32'hffff_fffc, 32'h0ffc);

		add_f3(k_br, f3_beq,  32'h5, 32'h5, 32'h1);
		add_f3(k_br, f3_beq,  32'h5, 32'h6, 32'h0);
		add_f3(k_br, f3_bne,  32'h5, 32'h6, 32'h1);
		add_f3(k_br, f3_bne,  32'h7, 32'h7, 32'h0);
		add_f3(k_br, f3_blt,  32'hffff_ffff, 32'h1, 32'h1);
		add_f3(k_br, f3_blt,  32'h3, 32'hffff_fffe, 32'h0);
		add_f3(k_br, f3_bge,  32'h1, 32'hffff_ffff, 32'h1);
		add_f3(k_br, f3_bge,  32'hffff_fffb, 32'h2, 32'h0);
		add_f3(k_br, f3_bltu, 32'h1, 32'hffff_ffff, 32'h1);
		add_f3(k_br, f3_bltu, 32'hffff_ffff, 32'h1, 32'h0);
		add_f3(k_br, f3_bgeu, 32'h2, 32'h2, 32'h1);
		add_f3(k_br, f3_bgeu, 32'h0, 32'h1, 32'h0);

		add_f3(k_mul, f3_mul,    32'h7, 32'hffff_fffd, 32'hffff_ffeb);
		add_f3(k_mul, f3_mul,    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
		add_f3(k_mul, f3_mulh,   32'h7, 32'hffff_fffd, 32'hffff_ffff);
		add_f3(k_mul, f3_mulh,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
		add_f3(k_mul, f3_mulhsu, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
		add_f3(k_mul, f3_mulhu,  32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
		add_f3(k_mul, f3_mulhu,  32'h8000_0000, 32'h2, 32'h1);

		add_f3(k_div, f3_div,  32'hffff_fff9, 32'h2, 32'hffff_fffd);
		add_f3(k_div, f3_rem,  32'hffff_fff9, 32'h2, 32'hffff_ffff);
		add_f3(k_div, f3_div,  32'h7, 32'hffff_fffe, 32'hffff_fffd);
		add_f3(k_div, f3_rem,  32'h7, 32'hffff_fffe, 32'h1);
		add_f3(k_div, f3_divu, 32'hffff_fff9, 32'h2, 32'h7fff_fffc);
		add_f3(k_div, f3_remu, 32'hffff_fff9, 32'h2, 32'h1);
		add_f3(k_div, f3_div,  32'h14, 32'h0, 32'hffff_ffff);             // Divide by zero
		add_f3(k_div, f3_remu, 32'h5, 32'h0, 32'h5);
		add_f3(k_div, f3_div,  32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);  // Overflow
		add_f3(k_div, f3_rem,  32'h8000_0000, 32'hffff_ffff, 32'h0);
	endtask

	// Starts on a falling edge and ends on one
	task automatic apply_entry(input entry_t e, input int hold);
		int   cycles;
		logic long_op;
		long_op  = e.alu_mul || e.alu_div;
		alu_op   = e.alu_op;
		src_sel  = e.src_sel;
		funct3   = e.funct3;
		branch   = e.branch;
		alu_mul  = e.alu_mul;
		alu_div  = e.alu_div;
		pc       = e.pc;
		src1     = e.src1;
		src2     = e.src2;
		imm      = e.imm;
		id_to_ex = 1'b1;
		@(negedge clock);
		id_to_ex = 1'b0;
		cycles   = 1;
		while (!exu_finished && cycles < 100) begin
			check_value("exu_stall", data_t'(exu_stall), data_t'(long_op));
			@(negedge clock);
			cycles++;
		end
		if (!exu_finished) begin
			error_count++;
			$display("exu_finished did not rise within %0d cycles of id_to_ex", cycles);
		end
		if (!long_op)
			check_value("alu latency", data_t'(cycles), data_t'(2));
		check_value("exu_stall", data_t'(exu_stall), data_t'(0));
		check_value("exu_result", exu_result, e.expected);
		check_value("zero_flag", data_t'(zero_flag), data_t'(e.expected == '0));
		repeat (hold) begin                               // Writeback holds off
			@(negedge clock);
			check_value("exu_result", exu_result, e.expected);
			check_value("exu_finished", data_t'(exu_finished), data_t'(1));
		end
		ex_to_wb = 1'b1;
		@(negedge clock);
		ex_to_wb = 1'b0;
		check_value("exu_finished", data_t'(exu_finished), data_t'(0));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		entry_t e;
		void'($urandom(44576));
		reset    = 1'b1;
		pc       = '0;
		src1     = '0;
		src2     = '0;
		imm      = '0;
		alu_op   = alu_add;
		src_sel  = rs1_rs2;
		funct3   = '0;
		branch   = 1'b0;
		alu_mul  = 1'b0;
		alu_div  = 1'b0;
		id_to_ex = 1'b0;
		ex_to_wb = 1'b0;
		fill_table();
		table_ready = 1'b1;
		repeat (2) @(negedge clock);
		reset = 1'b0;
		check_value("exu_finished", data_t'(exu_finished), data_t'(0));
		check_value("exu_stall", data_t'(exu_stall), data_t'(0));
		check_value("exu_result", exu_result, data_t'(0));

		foreach (entries[i])
			apply_entry(entries[i], i % 4);

		for (int i = 0; i < 40; i++) begin                // Random add and mul
			e         = '0;
			e.src_sel = rs1_rs2;
			e.alu_op  = alu_add;
			e.src1    = $urandom;
			e.src2    = $urandom;
			if (i % 2 == 0) begin
				e.expected = e.src1 + e.src2;
			end else begin
				e.alu_mul  = 1'b1;
				e.funct3   = f3_mul;
				e.expected = e.src1 * e.src2;               // Low word of the product
			end
			apply_entry(e, $urandom_range(3, 0));
		end

		$display("checks: %0d  errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		wait (table_ready);
		#((entries.size() + 40) * 50 * 20);
		$display("The run timed out before all entries were applied");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== flist.f ====
design/exu_width_pkg.sv
design/exu_op_pkg.sv
design/exu_alu.sv
design/exu_multiplier.sv
design/exu_divider.sv
design/exu.sv
verif/exu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module exu_tb -f flist.f -o exu_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/exu_sim > sim.log 2>&1 || echo "Simulation exited with an error status" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
